// File: design/ddr_config.svh
`ifndef DDR_CONFIG_SVH
`define DDR_CONFIG_SVH

// register file addressing
`define DDR_REGF_ADDR_W    10
`define DDR_REGF_WR_BASE   10'd1   // first byte read out on a write
`define DDR_REGF_RD_BASE   10'd10  // first byte stored on a read

// dynamic address of device index 0, index is added on top
`define DDR_DYN_ADDR_BASE  7'd8

// scl stall lengths in scl cycles
`define DDR_STALL_RESTART  5'd10
`define DDR_STALL_EXIT     5'd16

// bit counter values inside the crc value where the staller is asked in
`define DDR_BITCNT_W       6
`define DDR_STALL_BIT_A    6'd11
`define DDR_STALL_BIT_B    6'd12

`endif

// File: design/ddr_pkg.sv
package ddr_pkg;

  // frame phases of one regular transfer
  typedef enum logic [4:0] {
    st_idle        = 5'd0,
    st_cmd_pre     = 5'd1,
    st_rw_bit      = 5'd2,
    st_seven_zeros = 5'd3,
    st_address     = 5'd4,
    st_parity      = 5'd5,   // command or data parity, see data_parity flag
    st_ack_pre     = 5'd6,
    st_ack_wait    = 5'd7,
    st_data_byte1  = 5'd8,
    st_data_byte2  = 5'd9,
    st_data_pad    = 5'd10,  // dummy second byte of an odd count
    st_data_pre    = 5'd11,
    st_crc_pre1    = 5'd12,
    st_crc_pre2    = 5'd13,
    st_crc_token   = 5'd14,
    st_crc_value   = 5'd15,
    st_error       = 5'd16,
    st_restart     = 5'd17,
    st_exit        = 5'd18,
    st_turnaround  = 5'd19
  } ddr_state_t;

  // serializer modes of the phy
  typedef enum logic [3:0] {
    tx_seven_zeros     = 4'd0,
    tx_serial_address  = 4'd1,
    tx_special_pre     = 4'd2,  // command preamble 01
    tx_one_preamble    = 4'd3,
    tx_zero_preamble   = 4'd4,
    tx_serial_byte     = 4'd5,
    tx_calc_parity     = 4'd6,
    tx_crc_value       = 4'd7,
    tx_crc_token       = 4'd8,
    tx_restart_pattern = 4'd9,
    tx_exit_pattern    = 4'd10
  } ddr_tx_mode_t;

  // deserializer modes of the phy
  typedef enum logic [3:0] {
    rx_preamble     = 4'd0,
    rx_deser_byte   = 4'd3,
    rx_check_token  = 4'd4,
    rx_check_parity = 4'd5,
    rx_check_crc    = 4'd6,
    rx_error_wait   = 4'd7
  } ddr_rx_mode_t;

  typedef enum logic [3:0] {
    err_success = 4'd0,
    err_crc     = 4'd1,
    err_parity  = 4'd2,
    err_frame   = 4'd3,
    err_nack    = 4'd5
  } ddr_err_t;

  typedef struct packed {
    logic       toc;        // 1 exit, 0 restart
    logic [4:0] dev_index;
    logic       wr_rd;      // 1 read
  } ddr_xfer_req_t;

  typedef struct packed {
    logic         tx_en;
    ddr_tx_mode_t tx_mode;
    logic         rx_en;
    ddr_rx_mode_t rx_mode;
    logic         pp_od;    // 1 push pull
  } ddr_phy_cmd_t;

  typedef struct packed {
    logic tx_done;  // one cycle strobes
    logic rx_done;
    logic rx_pre;
    logic rx_error;
  } ddr_phy_sts_t;

  typedef struct packed {
    logic       en;
    logic [4:0] cycles;
  } ddr_stall_t;

endpackage

// File: design/ddr_frame_fsm.sv
`timescale 1ns/1ps

module ddr_frame_fsm
  import ddr_pkg::*;
(
  input  logic          i_sys_clk,
  input  logic          i_sys_rst,
  input  logic          i_engine_en,
  input  ddr_xfer_req_t i_xfer_req,
  input  ddr_phy_sts_t  i_phy_sts,
  input  logic          i_frmcnt_last,
  input  logic          i_err_hit,
  output ddr_state_t    o_state,
  output logic          o_step,
  output logic          o_data_parity,
  output logic          o_delay_done
);

  ddr_state_t state;
  ddr_state_t next_state;
  logic       phase_active;  // phy is working on this phase
  logic       data_parity;
  logic       delay_done;

  // no phy phase in idle or turnaround, ack_wait listens only after its delay
  always_comb
  begin
    case (state)
      st_idle, st_turnaround: phase_active = 1'b0;
      st_ack_wait:            phase_active = delay_done;
      default:                phase_active = 1'b1;
    endcase
  end

  assign o_step = phase_active & (i_phy_sts.tx_done | i_phy_sts.rx_done);

  always_comb
  begin
    next_state = state;  // hold the phase until the phy strobes
    case (state)
      st_idle:
        if (i_engine_en)
          next_state = st_cmd_pre;
      st_cmd_pre:
        if (o_step)
          next_state = st_rw_bit;
      st_rw_bit:
        if (o_step)
          next_state = st_seven_zeros;
      st_seven_zeros:
        if (o_step)
          next_state = st_address;
      st_address:
        if (o_step)
          next_state = st_parity;
      st_parity:
        if (o_step)
        begin
          if (!data_parity)
            next_state = st_ack_pre;           // end of command word
          else if (!i_xfer_req.wr_rd && i_frmcnt_last)
            next_state = st_crc_pre1;          // last word written
          else
            next_state = st_data_pre;
        end
      st_ack_pre:
        if (o_step)
          next_state = st_ack_wait;
      st_ack_wait:
        if (o_step)
          next_state = st_data_byte1;          // nack diverted by err_hit
      st_data_byte1:
        if (o_step)
          next_state = i_frmcnt_last ? st_data_pad : st_data_byte2;
      st_data_byte2, st_data_pad:
        if (o_step)
          next_state = st_parity;
      st_data_pre:
        if (o_step)
        begin
          if (i_xfer_req.wr_rd && !i_phy_sts.rx_pre)
            next_state = st_crc_pre2;          // target ends the read
          else
            next_state = st_data_byte1;
        end
      st_crc_pre1:
        if (o_step)
          next_state = st_crc_pre2;
      st_crc_pre2:
        if (o_step)
          next_state = st_crc_token;
      st_crc_token:
        if (o_step)
          next_state = st_crc_value;
      st_crc_value, st_error:
        if (o_step)
          next_state = i_xfer_req.toc ? st_exit : st_restart;
      st_restart, st_exit:
        if (o_step)
          next_state = st_turnaround;
      st_turnaround:
        if (delay_done)
          next_state = st_idle;              // second cycle
      default:
        next_state = st_idle;
    endcase
    if (i_err_hit)
      next_state = st_error;                 // any failing step
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      state       <= st_idle;
      data_parity <= 1'b0;
      delay_done  <= 1'b0;
    end
    else
    begin
      state <= next_state;
      // high from the second cycle of a delayed phase on
      delay_done <= (next_state == state) &&
                    ((state == st_ack_wait) || (state == st_turnaround));
      if ((state == st_data_byte1) || (state == st_data_byte2) || (state == st_data_pad))
        data_parity <= 1'b1;                 // next parity closes a data word
      else if (state == st_address)
        data_parity <= 1'b0;                 // next parity closes the command
    end
  end

  assign o_state       = state;
  assign o_data_parity = data_parity;
  assign o_delay_done  = delay_done;

endmodule

// File: design/ddr_phy_decode.sv
`timescale 1ns/1ps
`include "ddr_config.svh"

module ddr_phy_decode
  import ddr_pkg::*;
(
  input  ddr_state_t               i_state,
  input  ddr_xfer_req_t            i_xfer_req,
  input  logic                     i_data_parity,
  input  logic [`DDR_BITCNT_W-1:0] i_bitcnt,
  input  logic                     i_delay_done,
  output ddr_phy_cmd_t             o_phy_cmd,
  output logic [6:0]               o_tx_special_data,
  output logic                     o_regf_rd_en,
  output logic                     o_regf_wr_en,
  output logic                     o_frmcnt_en,
  output logic                     o_bitcnt_en,
  output logic                     o_bitcnt_rst,
  output ddr_stall_t               o_stall,
  output logic                     o_engine_done
);

  logic       is_rd;
  logic [4:0] stall_cycles;
  logic       stall_bit;

  assign is_rd        = i_xfer_req.wr_rd;
  assign stall_cycles = i_xfer_req.toc ? `DDR_STALL_EXIT : `DDR_STALL_RESTART;
  assign stall_bit    = (i_bitcnt == `DDR_STALL_BIT_A) || (i_bitcnt == `DDR_STALL_BIT_B);

  always_comb
  begin
    o_phy_cmd.tx_en   = 1'b0;
    o_phy_cmd.tx_mode = tx_seven_zeros;
    o_phy_cmd.rx_en   = 1'b0;
    o_phy_cmd.rx_mode = rx_preamble;
    o_phy_cmd.pp_od   = 1'b1;
    o_tx_special_data = 7'd0;
    o_regf_rd_en      = 1'b0;
    o_regf_wr_en      = 1'b0;
    o_frmcnt_en       = 1'b1;
    o_bitcnt_en       = 1'b1;
    o_bitcnt_rst      = 1'b0;
    o_stall.en        = 1'b0;
    o_stall.cycles    = 5'd0;
    o_engine_done     = 1'b0;

    case (i_state)
      st_idle:
      begin
        o_frmcnt_en = 1'b0;
        o_bitcnt_en = 1'b0;
      end
      st_cmd_pre:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = tx_special_pre;
        o_frmcnt_en       = 1'b0;  // frames count from the address on
      end
      st_rw_bit:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = is_rd ? tx_one_preamble : tx_zero_preamble;
        o_frmcnt_en       = 1'b0;
      end
      st_seven_zeros:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = tx_seven_zeros;
        o_frmcnt_en       = 1'b0;
      end
      st_address:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = tx_serial_address;
        o_tx_special_data = {2'b00, i_xfer_req.dev_index} + `DDR_DYN_ADDR_BASE;
      end
      st_parity:
        if (i_data_parity && is_rd)
        begin
          o_phy_cmd.rx_en   = 1'b1;
          o_phy_cmd.rx_mode = rx_check_parity;  // target sent the data word
        end
        else
        begin
          o_phy_cmd.tx_en   = 1'b1;
          o_phy_cmd.tx_mode = tx_calc_parity;
        end
      st_ack_pre:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = tx_one_preamble;
      end
      st_ack_wait:
      begin
        o_phy_cmd.rx_en   = i_delay_done;     // off for the first cycle
        o_phy_cmd.rx_mode = rx_preamble;
        o_phy_cmd.pp_od   = 1'b0;             // open drain for the ack bit
      end
      st_data_byte1, st_data_byte2, st_data_pad:
      begin
        if (is_rd)
        begin
          o_phy_cmd.rx_en   = 1'b1;
          o_phy_cmd.rx_mode = rx_deser_byte;
          o_regf_wr_en      = (i_state != st_data_pad);
        end
        else
        begin
          o_phy_cmd.tx_en   = 1'b1;
          o_phy_cmd.tx_mode = tx_serial_byte;
          o_regf_rd_en      = (i_state != st_data_pad);
        end
      end
      st_data_pre, st_crc_pre2:
        if (is_rd)
        begin
          o_phy_cmd.rx_en   = 1'b1;
          o_phy_cmd.rx_mode = rx_preamble;
        end
        else
        begin
          o_phy_cmd.tx_en   = 1'b1;
          o_phy_cmd.tx_mode = tx_one_preamble;
        end
      st_crc_pre1:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = tx_zero_preamble;
      end
      st_crc_token:
        if (is_rd)
        begin
          o_phy_cmd.rx_en   = 1'b1;
          o_phy_cmd.rx_mode = rx_check_token;
        end
        else
        begin
          o_phy_cmd.tx_en   = 1'b1;
          o_phy_cmd.tx_mode = tx_crc_token;
        end
      st_crc_value:
      begin
        if (is_rd)
        begin
          o_phy_cmd.rx_en   = 1'b1;
          o_phy_cmd.rx_mode = rx_check_crc;
        end
        else
        begin
          o_phy_cmd.tx_en   = 1'b1;
          o_phy_cmd.tx_mode = tx_crc_value;
        end
        o_stall.en     = stall_bit;           // stretch scl ahead of the pattern
        o_stall.cycles = stall_bit ? stall_cycles : 5'd0;
      end
      st_error:
      begin
        o_phy_cmd.rx_en   = 1'b1;
        o_phy_cmd.rx_mode = rx_error_wait;
        o_bitcnt_rst      = 1'b1;
      end
      st_restart, st_exit:
      begin
        o_phy_cmd.tx_en   = 1'b1;
        o_phy_cmd.tx_mode = (i_state == st_exit) ? tx_exit_pattern : tx_restart_pattern;
        o_stall.en        = 1'b1;
        o_stall.cycles    = stall_cycles;
      end
      st_turnaround:
      begin
        o_frmcnt_en   = 1'b0;
        o_bitcnt_en   = 1'b0;
        o_engine_done = i_delay_done;         // second turnaround cycle
      end
      default:
      begin
        o_frmcnt_en = 1'b0;
        o_bitcnt_en = 1'b0;
      end
    endcase
  end

endmodule

// File: design/ddr_regf_addr.sv
`timescale 1ns/1ps
`include "ddr_config.svh"

module ddr_regf_addr
  import ddr_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  ddr_state_t                  i_state,
  input  logic                        i_step,
  input  logic                        i_wr_rd,
  output logic [`DDR_REGF_ADDR_W-1:0] o_regf_addr
);

  logic load;
  logic incr;

  assign load = i_step && (i_state == st_ack_wait);  // ack seen, first byte next
  assign incr = i_step && ((i_state == st_data_byte1) || (i_state == st_data_byte2));

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      o_regf_addr <= '0;
    else if (load)
      o_regf_addr <= i_wr_rd ? `DDR_REGF_RD_BASE : `DDR_REGF_WR_BASE;
    else if (incr)
      o_regf_addr <= o_regf_addr + 1'b1;  // one per finished byte
  end

endmodule

// File: design/ddr_error_report.sv
`timescale 1ns/1ps

module ddr_error_report
  import ddr_pkg::*;
(
  input  logic         i_sys_clk,
  input  logic         i_sys_rst,
  input  ddr_state_t   i_state,
  input  logic         i_step,
  input  logic         i_wr_rd,
  input  ddr_phy_sts_t i_phy_sts,
  input  logic         i_data_parity,
  output logic         o_err_hit,
  output ddr_err_t     o_error_type
);

  ddr_err_t code;  // failure of the current phase if it ended now

  always_comb
  begin
    code = err_success;
    case (i_state)
      st_ack_wait:
        if (i_phy_sts.rx_pre)
          code = err_nack;                   // nobody pulled sda low
      st_parity:
        if (i_wr_rd && i_data_parity && i_phy_sts.rx_error)
          code = err_parity;
      st_crc_pre2:
        if (i_wr_rd && !i_phy_sts.rx_pre)
          code = err_frame;                  // crc preamble must be 1
      st_crc_token:
        if (i_wr_rd && i_phy_sts.rx_error)
          code = err_frame;
      st_crc_value:
        if (i_wr_rd && i_phy_sts.rx_error)
          code = err_crc;
      default:
        code = err_success;
    endcase
  end

  assign o_err_hit = i_step && (code != err_success);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      o_error_type <= err_success;
    else if (o_err_hit)
      o_error_type <= code;
    else if (i_step && (i_state == st_cmd_pre))
      o_error_type <= err_success;           // new transfer under way
  end

endmodule

// File: design/ddr_mode.sv
`timescale 1ns/1ps
`include "ddr_config.svh"

module ddr_mode
  import ddr_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_engine_en,
  input  ddr_xfer_req_t               i_xfer_req,
  input  logic                        i_frmcnt_last,
  input  logic [`DDR_BITCNT_W-1:0]    i_bitcnt,
  input  ddr_phy_sts_t                i_phy_sts,
  output ddr_phy_cmd_t                o_phy_cmd,
  output logic [6:0]                  o_tx_special_data,
  output logic                        o_regf_rd_en,
  output logic                        o_regf_wr_en,
  output logic [`DDR_REGF_ADDR_W-1:0] o_regf_addr,
  output logic                        o_frmcnt_en,
  output logic                        o_bitcnt_en,
  output logic                        o_bitcnt_rst,
  output ddr_stall_t                  o_stall,
  output ddr_err_t                    o_regf_error_type,
  output logic                        o_engine_done
);

  ddr_state_t state;
  logic       step;
  logic       data_parity;
  logic       delay_done;
  logic       err_hit;

  ddr_frame_fsm u_frame_fsm (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_xfer_req    (i_xfer_req),
    .i_phy_sts     (i_phy_sts),
    .i_frmcnt_last (i_frmcnt_last),
    .i_err_hit     (err_hit),
    .o_state       (state),
    .o_step        (step),
    .o_data_parity (data_parity),
    .o_delay_done  (delay_done)
  );

  ddr_phy_decode u_phy_decode (
    .i_state           (state),
    .i_xfer_req        (i_xfer_req),
    .i_data_parity     (data_parity),
    .i_bitcnt          (i_bitcnt),
    .i_delay_done      (delay_done),
    .o_phy_cmd         (o_phy_cmd),
    .o_tx_special_data (o_tx_special_data),
    .o_regf_rd_en      (o_regf_rd_en),
    .o_regf_wr_en      (o_regf_wr_en),
    .o_frmcnt_en       (o_frmcnt_en),
    .o_bitcnt_en       (o_bitcnt_en),
    .o_bitcnt_rst      (o_bitcnt_rst),
    .o_stall           (o_stall),
    .o_engine_done     (o_engine_done)
  );

  ddr_regf_addr u_regf_addr (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_state     (state),
    .i_step      (step),
    .i_wr_rd     (i_xfer_req.wr_rd),
    .o_regf_addr (o_regf_addr)
  );

  ddr_error_report u_error_report (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_state       (state),
    .i_step        (step),
    .i_wr_rd       (i_xfer_req.wr_rd),
    .i_phy_sts     (i_phy_sts),
    .i_data_parity (data_parity),
    .o_err_hit     (err_hit),
    .o_error_type  (o_regf_error_type)
  );

endmodule

// File: tests/ddr_mode_checker.sv
`timescale 1ns/1ps

module ddr_mode_checker
  import ddr_pkg::*;
(
  input logic         i_sys_clk,
  input logic         i_sys_rst,
  input ddr_phy_cmd_t i_phy_cmd,
  input logic         i_regf_rd_en,
  input logic         i_regf_wr_en,
  input ddr_stall_t   i_stall,
  input logic         i_bitcnt_rst,
  input ddr_err_t     i_error_type,
  input logic         i_engine_done
);

  // phy drives the line in one direction at a time
  a_one_direction: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    !(i_phy_cmd.tx_en && i_phy_cmd.rx_en))
    else $error("tx and rx enabled together");

  a_done_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_engine_done |=> !i_engine_done)
    else $error("engine done longer than one cycle");

  // everything quiet while reset is held
  a_reset_quiet: assert property (@(posedge i_sys_clk)
    !i_sys_rst |-> (!i_phy_cmd.tx_en && !i_phy_cmd.rx_en && !i_regf_rd_en && !i_regf_wr_en
                    && !i_stall.en && !i_bitcnt_rst && !i_engine_done
                    && (i_error_type == err_success)))
    else $error("outputs active during reset");

endmodule

bind ddr_mode ddr_mode_checker u_checker (
  .i_sys_clk     (i_sys_clk),
  .i_sys_rst     (i_sys_rst),
  .i_phy_cmd     (o_phy_cmd),
  .i_regf_rd_en  (o_regf_rd_en),
  .i_regf_wr_en  (o_regf_wr_en),
  .i_stall       (o_stall),
  .i_bitcnt_rst  (o_bitcnt_rst),
  .i_error_type  (o_regf_error_type),
  .i_engine_done (o_engine_done)
);

// File: tests/ddr_mode_monitor.sv
`timescale 1ns/1ps
`include "ddr_config.svh"

module ddr_mode_monitor
  import ddr_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_engine_en,
  input  ddr_xfer_req_t               i_xfer_req,
  input  logic                        i_frmcnt_last,
  input  logic [`DDR_BITCNT_W-1:0]    i_bitcnt,
  input  ddr_phy_sts_t                i_phy_sts,
  input  ddr_phy_cmd_t                i_phy_cmd,
  input  logic [6:0]                  i_tx_special_data,
  input  logic                        i_regf_rd_en,
  input  logic                        i_regf_wr_en,
  input  logic [`DDR_REGF_ADDR_W-1:0] i_regf_addr,
  input  logic                        i_frmcnt_en,
  input  logic                        i_bitcnt_en,
  input  logic                        i_bitcnt_rst,
  input  ddr_stall_t                  i_stall,
  input  ddr_err_t                    i_error_type,
  input  logic                        i_engine_done,
  output int                          o_errors
);

  ddr_state_t m_st;                        // model phase
  logic       m_delay;                     // second cycle of ack_wait or turnaround
  logic       m_dp;                        // next parity closes a data word
  ddr_err_t   m_code;
  logic [9:0] m_addr;
  logic       e_tx, e_rx, rd, stall_bit;
  logic [3:0] e_txm, e_rxm;
  int         starts, dones;

  assign rd        = i_xfer_req.wr_rd;
  assign stall_bit = (i_bitcnt == 6'd11) || (i_bitcnt == 6'd12);

  // what the phy must be doing in each phase
  always_comb
  begin
    e_tx  = 1'b0;
    e_rx  = 1'b0;
    e_txm = 4'd0;
    e_rxm = 4'd0;
    case (m_st)
      st_cmd_pre:     {e_tx, e_txm} = {1'b1, tx_special_pre};
      st_rw_bit:      {e_tx, e_txm} = {1'b1, rd ? tx_one_preamble : tx_zero_preamble};
      st_seven_zeros: {e_tx, e_txm} = {1'b1, tx_seven_zeros};
      st_address:     {e_tx, e_txm} = {1'b1, tx_serial_address};
      st_parity:
        if (m_dp && rd) {e_rx, e_rxm} = {1'b1, rx_check_parity};
        else            {e_tx, e_txm} = {1'b1, tx_calc_parity};
      st_ack_pre:     {e_tx, e_txm} = {1'b1, tx_one_preamble};
      st_ack_wait:    {e_rx, e_rxm} = {m_delay, rx_preamble};  // silent first cycle
      st_data_byte1, st_data_byte2, st_data_pad:
        if (rd) {e_rx, e_rxm} = {1'b1, rx_deser_byte};
        else    {e_tx, e_txm} = {1'b1, tx_serial_byte};
      st_data_pre, st_crc_pre2:
        if (rd) {e_rx, e_rxm} = {1'b1, rx_preamble};
        else    {e_tx, e_txm} = {1'b1, tx_one_preamble};
      st_crc_pre1:    {e_tx, e_txm} = {1'b1, tx_zero_preamble};
      st_crc_token:
        if (rd) {e_rx, e_rxm} = {1'b1, rx_check_token};
        else    {e_tx, e_txm} = {1'b1, tx_crc_token};
      st_crc_value:
        if (rd) {e_rx, e_rxm} = {1'b1, rx_check_crc};
        else    {e_tx, e_txm} = {1'b1, tx_crc_value};
      st_error:       {e_rx, e_rxm} = {1'b1, rx_error_wait};
      st_restart:     {e_tx, e_txm} = {1'b1, tx_restart_pattern};
      st_exit:        {e_tx, e_txm} = {1'b1, tx_exit_pattern};
      default:        e_tx = 1'b0;
    endcase
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("Mismatch %s expected %h got %h at %0t", name, exp, got, $time);
      o_errors++;
    end
  endtask

  // model steps with the dut clock
  always @(posedge i_sys_clk or negedge i_sys_rst)
  begin : model
    ddr_state_t nxt;
    ddr_err_t   fc;
    logic       step;
    if (!i_sys_rst)
    begin
      m_st    <= st_idle;
      m_delay <= 1'b0;
      m_dp    <= 1'b0;
      m_code  <= err_success;
      m_addr  <= '0;
    end
    else
    begin
      step = (e_tx && i_phy_sts.tx_done) || (e_rx && i_phy_sts.rx_done);
      fc   = err_success;
      nxt  = m_st;
      case (m_st)
        st_ack_wait:  if (i_phy_sts.rx_pre) fc = err_nack;
        st_parity:    if (rd && m_dp && i_phy_sts.rx_error) fc = err_parity;
        st_crc_pre2:  if (rd && !i_phy_sts.rx_pre) fc = err_frame;
        st_crc_token: if (rd && i_phy_sts.rx_error) fc = err_frame;
        st_crc_value: if (rd && i_phy_sts.rx_error) fc = err_crc;
        default:      fc = err_success;
      endcase
      case (m_st)
        st_idle:        if (i_engine_en) nxt = st_cmd_pre;
        st_cmd_pre:     nxt = step ? st_rw_bit : m_st;
        st_rw_bit:      nxt = step ? st_seven_zeros : m_st;
        st_seven_zeros: nxt = step ? st_address : m_st;
        st_address:     nxt = step ? st_parity : m_st;
        st_parity:
          if (step)
            nxt = !m_dp ? st_ack_pre : (!rd && i_frmcnt_last) ? st_crc_pre1 : st_data_pre;
        st_ack_pre:     nxt = step ? st_ack_wait : m_st;
        st_ack_wait:    nxt = step ? st_data_byte1 : m_st;
        st_data_byte1:  if (step) nxt = i_frmcnt_last ? st_data_pad : st_data_byte2;
        st_data_byte2, st_data_pad: nxt = step ? st_parity : m_st;
        st_data_pre:
          if (step) nxt = (rd && !i_phy_sts.rx_pre) ? st_crc_pre2 : st_data_byte1;
        st_crc_pre1:    nxt = step ? st_crc_pre2 : m_st;
        st_crc_pre2:    nxt = step ? st_crc_token : m_st;
        st_crc_token:   nxt = step ? st_crc_value : m_st;
        st_crc_value, st_error:
          if (step) nxt = i_xfer_req.toc ? st_exit : st_restart;
        st_restart, st_exit: nxt = step ? st_turnaround : m_st;
        st_turnaround:  nxt = m_delay ? st_idle : m_st;
        default:        nxt = st_idle;
      endcase
      if (step && fc != err_success)
      begin
        nxt    = st_error;
        m_code <= fc;
      end
      else if (step && m_st == st_cmd_pre)
        m_code <= err_success;
      if (step && m_st == st_ack_wait)
        m_addr <= rd ? 10'd10 : 10'd1;
      else if (step && (m_st == st_data_byte1 || m_st == st_data_byte2))
        m_addr <= m_addr + 10'd1;
      if (m_st == st_data_byte1 || m_st == st_data_byte2 || m_st == st_data_pad)
        m_dp <= 1'b1;
      else if (m_st == st_address)
        m_dp <= 1'b0;
      m_delay <= (nxt == m_st) && (m_st == st_ack_wait || m_st == st_turnaround);
      m_st    <= nxt;
    end
  end

  // outputs have settled by the falling edge
  always @(negedge i_sys_clk)
  begin : compare
    logic e_rd_en, e_wr_en, e_stall, e_bit_en, e_frm_en;
    e_rd_en  = !rd && (m_st == st_data_byte1 || m_st == st_data_byte2);
    e_wr_en  = rd && (m_st == st_data_byte1 || m_st == st_data_byte2);
    e_stall  = (m_st == st_restart) || (m_st == st_exit) || (m_st == st_crc_value && stall_bit);
    e_bit_en = (m_st != st_idle) && (m_st != st_turnaround);  // a frame is on the bus
    e_frm_en = e_bit_en && !(m_st inside {st_cmd_pre, st_rw_bit, st_seven_zeros});
    check("tx_en", 32'(e_tx), 32'(i_phy_cmd.tx_en));
    check("rx_en", 32'(e_rx), 32'(i_phy_cmd.rx_en));
    if (e_tx)
      check("tx_mode", 32'(e_txm), 32'(i_phy_cmd.tx_mode));
    if (e_rx)
      check("rx_mode", 32'(e_rxm), 32'(i_phy_cmd.rx_mode));
    check("pp_od", 32'(m_st != st_ack_wait), 32'(i_phy_cmd.pp_od));  // target drives the ack
    if (m_st == st_address)
      check("tx_special_data", 32'(i_xfer_req.dev_index + 7'd8), 32'(i_tx_special_data));
    check("regf_rd_en", 32'(e_rd_en), 32'(i_regf_rd_en));
    check("regf_wr_en", 32'(e_wr_en), 32'(i_regf_wr_en));
    if (e_rd_en || e_wr_en)
      check("regf_addr", 32'(m_addr), 32'(i_regf_addr));
    check("frmcnt_en", 32'(e_frm_en), 32'(i_frmcnt_en));
    check("bitcnt_en", 32'(e_bit_en), 32'(i_bitcnt_en));
    check("stall_en", 32'(e_stall), 32'(i_stall.en));
    if (i_stall.en)
      check("stall_cycles", 32'(i_xfer_req.toc ? 5'd16 : 5'd10), 32'(i_stall.cycles));
    check("bitcnt_rst", 32'(m_st == st_error), 32'(i_bitcnt_rst));
    check("engine_done", 32'((m_st == st_turnaround) && m_delay), 32'(i_engine_done));
    check("regf_error_type", 32'(m_code), 32'(i_error_type));
    if (i_engine_done)
      dones++;
    // start is taken on the coming rising edge
    if (m_st == st_idle && i_engine_en)
    begin
      if (starts != dones)
      begin
        $display("Transfer started before the previous one reported done at %0t", $time);
        o_errors++;
      end
      starts++;
    end
  end

  initial
  begin
    o_errors = 0;
    starts   = 0;
    dones    = 0;
  end

endmodule

// File: tests/ddr_mode_tb.sv
`timescale 1ns/1ps
`include "ddr_config.svh"

module ddr_mode_tb
  import ddr_pkg::*;
();

  localparam int NUM_XFER   = 60;
  localparam int MAX_PHASES = 32;                                  // longest read with 4 words
  localparam int LIMIT_NS   = NUM_XFER * MAX_PHASES * 5 * 10 + 5000;

  logic                        i_sys_clk;
  logic                        i_sys_rst;
  logic                        i_engine_en;
  ddr_xfer_req_t               i_xfer_req;
  logic                        i_frmcnt_last;
  logic [`DDR_BITCNT_W-1:0]    i_bitcnt;
  ddr_phy_sts_t                i_phy_sts;
  ddr_phy_cmd_t                o_phy_cmd;
  logic [6:0]                  o_tx_special_data;
  logic                        o_regf_rd_en, o_regf_wr_en;
  logic [`DDR_REGF_ADDR_W-1:0] o_regf_addr;
  logic                        o_frmcnt_en, o_bitcnt_en, o_bitcnt_rst;
  ddr_stall_t                  o_stall;
  ddr_err_t                    o_regf_error_type;
  logic                        o_engine_done;
  int                          mon_errors;
  logic [31:0]                 lfsr;
  int                          done_xfers;

  ddr_mode i_ddr_mode (.*);

  ddr_mode_monitor u_monitor (
    .i_sys_clk (i_sys_clk), .i_sys_rst (i_sys_rst), .i_engine_en (i_engine_en),
    .i_xfer_req (i_xfer_req), .i_frmcnt_last (i_frmcnt_last), .i_bitcnt (i_bitcnt),
    .i_phy_sts (i_phy_sts), .i_phy_cmd (o_phy_cmd), .i_tx_special_data (o_tx_special_data),
    .i_regf_rd_en (o_regf_rd_en), .i_regf_wr_en (o_regf_wr_en), .i_regf_addr (o_regf_addr),
    .i_frmcnt_en (o_frmcnt_en), .i_bitcnt_en (o_bitcnt_en),
    .i_bitcnt_rst (o_bitcnt_rst), .i_stall (o_stall), .i_error_type (o_regf_error_type),
    .i_engine_done (o_engine_done), .o_errors (mon_errors)
  );

  always #5 i_sys_clk = ~i_sys_clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // acts as the phy for one transfer, fail 1 nack 2 parity 3 crc pre 4 token 5 crc
  task automatic run_transfer();
    logic [31:0] r;
    int          nwords, fail, gap, word_idx, crc_cyc;
    logic        data_seen, crc_phase, pend_word, is_rx;
    rand_bits(7, r);
    i_xfer_req = r[6:0];
    rand_bits(2, r);
    nwords = r + 1;
    rand_bits(3, r);
    fail = i_xfer_req.wr_rd ? ((r > 5) ? 0 : r) : ((r == 1) ? 1 : 0);
    rand_bits(2, r);
    gap       = r + 1;
    word_idx  = 0;
    crc_cyc   = 0;
    data_seen = 1'b0;
    crc_phase = 1'b0;
    pend_word = 1'b0;
    i_frmcnt_last = (nwords == 1);
    i_engine_en   = 1'b1;
    @(posedge i_sys_clk);
    #1;
    i_engine_en = 1'b0;
    while (!o_engine_done)
    begin
      i_phy_sts = '0;
      if (pend_word)
        word_idx++;
      pend_word     = 1'b0;
      i_frmcnt_last = (word_idx == nwords - 1);
      is_rx = o_phy_cmd.rx_en;
      if ((o_phy_cmd.tx_en && o_phy_cmd.tx_mode == tx_crc_value) ||
          (is_rx && o_phy_cmd.rx_mode == rx_check_crc))
      begin
        i_bitcnt = 6'(9 + crc_cyc);       // sweeps across the stall positions
        crc_cyc++;
      end
      else
        i_bitcnt = '0;
      if (o_phy_cmd.tx_en || is_rx)
      begin
        if (gap > 1)
          gap--;
        else
        begin
          rand_bits(2, r);
          gap = r + 1;
          i_phy_sts.tx_done = o_phy_cmd.tx_en;
          i_phy_sts.rx_done = is_rx;
          if ((o_phy_cmd.tx_en && o_phy_cmd.tx_mode == tx_serial_byte) ||
              (is_rx && o_phy_cmd.rx_mode == rx_deser_byte))
            data_seen = 1'b1;
          if (data_seen && ((o_phy_cmd.tx_en && o_phy_cmd.tx_mode == tx_calc_parity) ||
                            (is_rx && o_phy_cmd.rx_mode == rx_check_parity)))
            pend_word = 1'b1;
          if (is_rx && o_phy_cmd.rx_mode == rx_preamble)
          begin
            if (!data_seen)
              i_phy_sts.rx_pre = (fail == 1);      // ack is a low bit
            else if (!crc_phase)
            begin
              i_phy_sts.rx_pre = (word_idx < nwords);
              crc_phase        = !i_phy_sts.rx_pre;
            end
            else
              i_phy_sts.rx_pre = (fail != 3);
          end
          i_phy_sts.rx_error = is_rx &&
            ((o_phy_cmd.rx_mode == rx_check_parity && fail == 2) ||
             (o_phy_cmd.rx_mode == rx_check_token && fail == 4) ||
             (o_phy_cmd.rx_mode == rx_check_crc && fail == 5));
        end
      end
      @(posedge i_sys_clk);
      #1;
    end
    i_phy_sts = '0;
    i_bitcnt  = '0;
    @(posedge i_sys_clk);                  // controller back in idle for the next start
    #1;
    done_xfers++;
  endtask

  initial
  begin
    i_sys_clk     = 1'b0;
    i_sys_rst     = 1'b0;
    i_engine_en   = 1'b0;
    i_xfer_req    = '0;
    i_frmcnt_last = 1'b0;
    i_bitcnt      = '0;
    i_phy_sts     = '0;
    lfsr          = 32'h461c_e4c8;
    done_xfers    = 0;
    repeat (5) @(posedge i_sys_clk);
    #1;
    i_sys_rst = 1'b1;
    repeat (2) @(posedge i_sys_clk);
    #1;
    for (int n = 0; n < NUM_XFER; n++)
      run_transfer();
    repeat (3) @(posedge i_sys_clk);
    $display("%0d transfers run, %0d errors", done_xfers, mon_errors);
    if (mon_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("Timeout after %0d transfers, the controller stopped answering", done_xfers);
    $display("%0d transfers run, %0d errors", done_xfers, mon_errors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: ddr_mode.f
+incdir+design
design/ddr_pkg.sv
design/ddr_frame_fsm.sv
design/ddr_phy_decode.sv
design/ddr_regf_addr.sv
design/ddr_error_report.sv
design/ddr_mode.sv
tests/ddr_mode_checker.sv
tests/ddr_mode_monitor.sv
tests/ddr_mode_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= ddr_mode_tb
RTL_TOP   ?= ddr_mode
FILELIST  ?= ddr_mode.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
